// File: tank_config.svh
/* Tank arena configuration */

`ifndef TANK_CONFIG_SVH
`define TANK_CONFIG_SVH

// ----------------------------------------------------------------------
// Playfield bounds, inclusive pixel coordinates
// ----------------------------------------------------------------------
`define TANK_X_MIN 0                // Left edge of the screen
`define TANK_X_MAX 639              // Right edge of the screen
`define TANK_Y_MIN 0                // Top edge of the screen
`define TANK_Y_MAX 479              // Bottom edge of the screen

// ----------------------------------------------------------------------
// Tank geometry and motion
// ----------------------------------------------------------------------
`define TANK_SIZE 10                // Half-width of the tank box
`define TANK_STEP_SHIFT 4           // Trig magnitude >> 4 gives 0..7 px
`define ANGLE_COUNT 45              // Headings in 8 degree steps

// Start positions, both tanks face +X after reset
`define TANK1_START_X 200
`define TANK1_START_Y 250
`define TANK2_START_X 440
`define TANK2_START_Y 250

`define HIT_COUNT_WIDTH 16          // Collision counter width

`endif

// File: tank_pkg.sv
/* Tank arena types */

package tank_pkg;

    // ------------------------------------------------------------------
    // Screen and heading types
    // ------------------------------------------------------------------

    // Unsigned pixel coordinate, wide enough for 0..639
    typedef logic [9:0] coordT;

    // Heading index 0..44, 8 degrees per step, 0 points along +X
    typedef logic [5:0] angleT;

    // Sign-magnitude trig value
    // bit 7 is the sign, bits 6:0 are the magnitude scaled by 127
    typedef logic [7:0] trigT;

    // ------------------------------------------------------------------
    // Per-player movement command
    // ------------------------------------------------------------------
    typedef enum logic [2:0]
    {
        cmdNone,                    // No key held, tank stays put
        cmdForward,                 // Move along the heading
        cmdBackward,                // Move against the heading
        cmdTurnLeft,                // Heading +1, counter clockwise
        cmdTurnRight                // Heading -1, clockwise
    } tankCmdT;

endpackage

// File: keyboardDecoder.sv
/* Key packet receiver and decoder */

`timescale 1ns/1ps

module keyboardDecoder
(
    input  logic             Reset,         // Frame tick
    input  logic             frame_clk,     // Async reset, active high
    input  logic             keyReq,        // Host has a packet
    input  logic [31:0]      keycode,       // Four held key codes
    output logic             keyAck,        // Four-phase acknowledge
    output tank_pkg::tankCmdT cmd1,         // Player 1 command
    output tank_pkg::tankCmdT cmd2          // Player 2 command
);

    import tank_pkg::*;

    // ------------------------------------------------------------------
    // USB HID usage codes per player
    // ------------------------------------------------------------------
    localparam logic [7:0] KeyW     = 8'h1A;    // P1 forward
    localparam logic [7:0] KeyS     = 8'h16;    // P1 backward
    localparam logic [7:0] KeyA     = 8'h04;    // P1 turn left
    localparam logic [7:0] KeyD     = 8'h07;    // P1 turn right
    localparam logic [7:0] KeyUp    = 8'h52;    // P2 forward
    localparam logic [7:0] KeyDown  = 8'h51;    // P2 backward
    localparam logic [7:0] KeyLeft  = 8'h50;    // P2 turn left
    localparam logic [7:0] KeyRight = 8'h4F;    // P2 turn right

    tankCmdT dec1;                              // Decoded, not yet latched
    tankCmdT dec2;

    // True when any of the four bytes holds the key
    function automatic logic hasKey(input logic [31:0] code, input logic [7:0] key);
        return (code[31:24] == key) || (code[23:16] == key) ||
               (code[15:8] == key) || (code[7:0] == key);
    endfunction

    // Fixed priority, forward wins over backward over turns
    function automatic tankCmdT decodePlayer(input logic [31:0] code,
                                             input logic [7:0] fwd, input logic [7:0] bwd,
                                             input logic [7:0] lft, input logic [7:0] rgt);
        tankCmdT res;
        if (hasKey(code, fwd))
            res = cmdForward;
        else if (hasKey(code, bwd))
            res = cmdBackward;
        else if (hasKey(code, lft))
            res = cmdTurnLeft;
        else if (hasKey(code, rgt))
            res = cmdTurnRight;
        else
            res = cmdNone;
        return res;
    endfunction

    always_comb
    begin
        dec1 = decodePlayer(keycode, KeyW, KeyS, KeyA, KeyD);
        dec2 = decodePlayer(keycode, KeyUp, KeyDown, KeyLeft, KeyRight);
    end

    // Ack follows req one edge late, commands latch as ack rises
    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            keyAck <= 1'b0;
            cmd1   <= cmdNone;
            cmd2   <= cmdNone;
        end
        else if (keyReq && !keyAck)
        begin
            keyAck <= 1'b1;                     // Phase 2, packet taken
            cmd1   <= dec1;                     // Held until next packet
            cmd2   <= dec2;
        end
        else if (!keyReq)
            keyAck <= 1'b0;                     // Phase 4, ready again
    end

endmodule

// File: trigTable.sv
/* Sine and cosine ROM */

`timescale 1ns/1ps

`include "tank_config.svh"

module trigTable
(
    input  tank_pkg::angleT angle,          // Heading index
    output tank_pkg::trigT  sinVal,         // Sign-magnitude sine
    output tank_pkg::trigT  cosVal          // Sign-magnitude cosine
);

    import tank_pkg::*;

    // One word per heading, sine in the upper byte, cosine in the lower
    logic [15:0] rom [0:`ANGLE_COUNT-1];

    initial
    begin
        $readmemh("trig.mem", rom);
    end

    // ------------------------------------------------------------------
    // Lookup, out-of-range headings read as zero
    // ------------------------------------------------------------------
    always_comb
    begin
        if (angle < `ANGLE_COUNT)
        begin
            sinVal = trigT'(rom[angle][15:8]);
            cosVal = trigT'(rom[angle][7:0]);
        end
        else
        begin
            sinVal = '0;                    // No motion for a bad index
            cosVal = '0;
        end
    end

endmodule

// File: tankMotion.sv
/* Tank heading and position engine */

`timescale 1ns/1ps

`include "tank_config.svh"

module tankMotion
#(
    parameter tank_pkg::coordT startX = tank_pkg::coordT'(`TANK1_START_X),
    parameter tank_pkg::coordT startY = tank_pkg::coordT'(`TANK1_START_Y)
)
(
    input  logic              Reset,        // Frame tick
    input  logic              frame_clk,    // Async reset, active high
    input  tank_pkg::tankCmdT cmd,          // Active command this frame
    output tank_pkg::coordT   x,            // Tank center X
    output tank_pkg::coordT   y,            // Tank center Y
    output tank_pkg::angleT   angle         // Heading index
);

    import tank_pkg::*;

    // ------------------------------------------------------------------
    // Clamp limits, the box edge stays on screen
    // ------------------------------------------------------------------
    localparam logic signed [11:0] XLo = 12'(`TANK_X_MIN + `TANK_SIZE);
    localparam logic signed [11:0] XHi = 12'(`TANK_X_MAX - `TANK_SIZE);
    localparam logic signed [11:0] YLo = 12'(`TANK_Y_MIN + `TANK_SIZE);
    localparam logic signed [11:0] YHi = 12'(`TANK_Y_MAX - `TANK_SIZE);
    localparam angleT AngleLast = angleT'(`ANGLE_COUNT - 1);

    trigT  sinVal;                          // From the ROM
    trigT  cosVal;
    logic signed [11:0] dx;                 // Signed step this frame
    logic signed [11:0] dy;
    logic signed [11:0] rawX;               // Unclamped next position
    logic signed [11:0] rawY;
    coordT nextX;
    coordT nextY;
    angleT nextAngle;

    // Sign-magnitude to signed step, flip inverts the direction
    function automatic logic signed [11:0] toDisp(input trigT val, input logic flip);
        logic [6:0]         mag;
        logic signed [11:0] disp;
        mag  = val[6:0] >> `TANK_STEP_SHIFT;
        disp = $signed({5'b00000, mag});
        return (val[7] ^ flip) ? -disp : disp;
    endfunction

    // Pin one axis into [lo, hi]
    function automatic coordT clampAxis(input logic signed [11:0] pos,
                                        input logic signed [11:0] lo,
                                        input logic signed [11:0] hi);
        coordT res;
        if (pos < lo)
            res = lo[9:0];
        else if (pos > hi)
            res = hi[9:0];
        else
            res = pos[9:0];
        return res;
    endfunction

    trigTable trig_i
    (
        .angle  (angle),
        .sinVal (sinVal),
        .cosVal (cosVal)
    );

    // ------------------------------------------------------------------
    // Next state from the current heading
    // ------------------------------------------------------------------
    always_comb
    begin
        dx        = '0;
        dy        = '0;
        nextAngle = angle;
        case (cmd)
            cmdForward:
            begin
                dx = toDisp(cosVal, 1'b0);
                dy = toDisp(sinVal, 1'b1);      // Screen y grows downward
            end
            cmdBackward:
            begin
                dx = toDisp(cosVal, 1'b1);      // Both signs reversed
                dy = toDisp(sinVal, 1'b0);
            end
            cmdTurnLeft:
                nextAngle = (angle == AngleLast) ? '0 : angle + 6'd1;
            cmdTurnRight:
                nextAngle = (angle == '0) ? AngleLast : angle - 6'd1;
            default: ;                          // cmdNone holds everything
        endcase
        rawX  = $signed({2'b00, x}) + dx;
        rawY  = $signed({2'b00, y}) + dy;
        nextX = clampAxis(rawX, XLo, XHi);      // Slides along a wall
        nextY = clampAxis(rawY, YLo, YHi);
    end

    // One update per frame
    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            x     <= startX;
            y     <= startY;
            angle <= '0;                        // Facing +X
        end
        else
        begin
            x     <= nextX;
            y     <= nextY;
            angle <= nextAngle;
        end
    end

endmodule

// File: hitDetector.sv
/* Tank collision detector */

`timescale 1ns/1ps

`include "tank_config.svh"

module hitDetector
(
    input  logic                        Reset,      // Frame tick
    input  logic                        frame_clk,  // Async reset, active high
    input  tank_pkg::coordT             x1,         // Tank 1 center
    input  tank_pkg::coordT             y1,
    input  tank_pkg::coordT             x2,         // Tank 2 center
    input  tank_pkg::coordT             y2,
    output logic                        hit,        // Boxes overlapped last frame
    output logic [`HIT_COUNT_WIDTH-1:0] hitCount    // Collisions seen
);

    import tank_pkg::*;

    localparam coordT Reach = coordT'(2 * `TANK_SIZE);  // Sum of two half-widths

    coordT distX;                           // |x1 - x2|
    coordT distY;                           // |y1 - y2|
    logic  overlap;

    // ------------------------------------------------------------------
    // Box overlap on both axes
    // ------------------------------------------------------------------
    always_comb
    begin
        distX   = (x1 >= x2) ? x1 - x2 : x2 - x1;
        distY   = (y1 >= y2) ? y1 - y2 : y2 - y1;
        overlap = (distX < Reach) && (distY < Reach);
    end

    // Flag and counter move together, count bumps as the flag rises
    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            hit      <= 1'b0;
            hitCount <= '0;
        end
        else
        begin
            hit <= overlap;
            if (overlap && !hit && (hitCount != '1))
                hitCount <= hitCount + 1'b1;    // Saturates at all ones
        end
    end

endmodule

// File: tankArena.sv
/* Two-player tank arena top */

`timescale 1ns/1ps

`include "tank_config.svh"

module tankArena
(
    input  logic                        Reset,      // Frame tick
    input  logic                        frame_clk,  // Async reset, active high
    input  logic                        keyReq,     // Host packet request
    input  logic [31:0]                 keycode,    // Four held keys
    output logic                        keyAck,     // Packet acknowledge
    output tank_pkg::coordT             tank1X,
    output tank_pkg::coordT             tank1Y,
    output tank_pkg::angleT             tank1Angle,
    output tank_pkg::coordT             tank2X,
    output tank_pkg::coordT             tank2Y,
    output tank_pkg::angleT             tank2Angle,
    output logic                        hit,        // Tanks touched last frame
    output logic [`HIT_COUNT_WIDTH-1:0] hitCount
);

    import tank_pkg::*;

    tankCmdT cmd1;                          // Latched player commands
    tankCmdT cmd2;

    // ------------------------------------------------------------------
    // Key packet to commands
    // ------------------------------------------------------------------
    keyboardDecoder dec_i
    (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .keyReq    (keyReq),
        .keycode   (keycode),
        .keyAck    (keyAck),
        .cmd1      (cmd1),
        .cmd2      (cmd2)
    );

    // ------------------------------------------------------------------
    // Motion engines, same logic at different start points
    // ------------------------------------------------------------------
    tankMotion #(.startX(coordT'(`TANK1_START_X)), .startY(coordT'(`TANK1_START_Y))) u_tank1
    (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .cmd       (cmd1),
        .x         (tank1X),
        .y         (tank1Y),
        .angle     (tank1Angle)
    );

    tankMotion #(.startX(coordT'(`TANK2_START_X)), .startY(coordT'(`TANK2_START_Y))) u_tank2
    (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .cmd       (cmd2),
        .x         (tank2X),
        .y         (tank2Y),
        .angle     (tank2Angle)
    );

    hitDetector hit_i
    (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .x1        (tank1X),
        .y1        (tank1Y),
        .x2        (tank2X),
        .y2        (tank2Y),
        .hit       (hit),
        .hitCount  (hitCount)
    );

endmodule

// File: tankArena_assertions.sv
/* Arena handshake and bounds checks */

`timescale 1ns/1ps

`include "tank_config.svh"

module tankArena_assertions
(
    input logic            Reset,           // Frame tick
    input logic            frame_clk,       // Async reset, active high
    input logic            keyReq,
    input logic            keyAck,
    input tank_pkg::coordT tank1X,
    input tank_pkg::coordT tank1Y,
    input tank_pkg::angleT tank1Angle,
    input tank_pkg::coordT tank2X,
    input tank_pkg::coordT tank2Y,
    input tank_pkg::angleT tank2Angle
);

    import tank_pkg::*;

    // True when a center sits inside the clamped playfield
    function automatic logic onField(input coordT x, input coordT y);
        return (int'(x) >= `TANK_X_MIN + `TANK_SIZE) && (int'(x) <= `TANK_X_MAX - `TANK_SIZE) &&
               (int'(y) >= `TANK_Y_MIN + `TANK_SIZE) && (int'(y) <= `TANK_Y_MAX - `TANK_SIZE);
    endfunction

    // ------------------------------------------------------------------
    // Ack only answers a request seen on the previous edge
    // ------------------------------------------------------------------
    ackFollowsReq: assert property (@(posedge Reset) disable iff (frame_clk)
        $rose(keyAck) |-> $past(keyReq))
        else $error("keyAck rose while keyReq was low");

    tank1OnField: assert property (@(posedge Reset) disable iff (frame_clk)
        onField(tank1X, tank1Y))
        else $error("Tank 1 left the clamped playfield");

    tank2OnField: assert property (@(posedge Reset) disable iff (frame_clk)
        onField(tank2X, tank2Y))
        else $error("Tank 2 left the clamped playfield");

    // Headings stay inside the table
    anglesInRange: assert property (@(posedge Reset) disable iff (frame_clk)
        (int'(tank1Angle) < `ANGLE_COUNT) && (int'(tank2Angle) < `ANGLE_COUNT))
        else $error("Heading index beyond the last table entry");

endmodule

bind tankArena tankArena_assertions chk_i
(
    .Reset      (Reset),
    .frame_clk  (frame_clk),
    .keyReq     (keyReq),
    .keyAck     (keyAck),
    .tank1X     (tank1X),
    .tank1Y     (tank1Y),
    .tank1Angle (tank1Angle),
    .tank2X     (tank2X),
    .tank2Y     (tank2Y),
    .tank2Angle (tank2Angle)
);

// File: tb_tankArena.sv
/* Tank arena testbench */

`timescale 1ns/1ps

`include "tank_config.svh"

module tb_tankArena;

    import tank_pkg::*;

    typedef logic [`HIT_COUNT_WIDTH-1:0] countT;

    localparam int AckLimit = 10;               // Frames allowed per handshake phase

    logic        Reset;                         // Frame clock
    logic        frame_clk;                     // Reset
    logic        keyReq;
    logic [31:0] keycode;
    logic        keyAck;
    coordT       tank1X, tank1Y, tank2X, tank2Y;
    angleT       tank1Angle, tank2Angle;
    logic        hit;
    countT       hitCount;

    logic [15:0] trigRom [0:`ANGLE_COUNT-1];    // Same table the ROM uses
    string       names[$];                      // Stimulus table columns
    logic [31:0] codes[$];
    int          holds[$];
    int          expHits[$];                    // -1 means no fixed total

    coordT   mX1, mY1, mX2, mY2;                // Reference model state
    angleT   mA1, mA2;
    tankCmdT mAct1, mAct2;
    logic    mHit;
    int      mCount;
    logic    prevAck;
    int      valueErrors = 0;
    int      protoErrors = 0;
    int      cycles = 0;
    int      cycleLimit = 0;

    tankArena dut_i
    (
        .Reset      (Reset),
        .frame_clk  (frame_clk),
        .keyReq     (keyReq),
        .keycode    (keycode),
        .keyAck     (keyAck),
        .tank1X     (tank1X),
        .tank1Y     (tank1Y),
        .tank1Angle (tank1Angle),
        .tank2X     (tank2X),
        .tank2Y     (tank2Y),
        .tank2Angle (tank2Angle),
        .hit        (hit),
        .hitCount   (hitCount)
    );

    initial
    begin
        Reset = 1'b0;
        forever #4 Reset = ~Reset;              // 8 ns frame period
    end

    // ------------------------------------------------------------------
    // Reference model, one step per frame
    // ------------------------------------------------------------------
    function automatic logic holdsKey(input logic [31:0] code, input logic [7:0] key);
        return (code[31:24] == key) || (code[23:16] == key) ||
               (code[15:8] == key) || (code[7:0] == key);
    endfunction

    function automatic tankCmdT pickCommand(input logic [31:0] code,
                                            input logic [7:0] fwd, input logic [7:0] bwd,
                                            input logic [7:0] lft, input logic [7:0] rgt);
        if (holdsKey(code, fwd))
            return cmdForward;
        if (holdsKey(code, bwd))
            return cmdBackward;
        if (holdsKey(code, lft))
            return cmdTurnLeft;
        if (holdsKey(code, rgt))
            return cmdTurnRight;
        return cmdNone;
    endfunction

    function automatic int clampInt(input int v, input int lo, input int hi);
        return (v < lo) ? lo : ((v > hi) ? hi : v);
    endfunction

    task automatic moveTank(inout coordT x, inout coordT y, inout angleT a, input tankCmdT c);
        int sMag, cMag, dx, dy, sgn;
        sMag = int'(trigRom[a][14:8]) >> `TANK_STEP_SHIFT;
        cMag = int'(trigRom[a][6:0]) >> `TANK_STEP_SHIFT;
        dx   = trigRom[a][7] ? -cMag : cMag;
        dy   = trigRom[a][15] ? sMag : -sMag;   // Screen y points down
        sgn  = (c == cmdBackward) ? -1 : 1;
        if (c == cmdForward || c == cmdBackward)
        begin
            x = coordT'(clampInt(int'(x) + sgn * dx, `TANK_X_MIN + `TANK_SIZE,
                                 `TANK_X_MAX - `TANK_SIZE));
            y = coordT'(clampInt(int'(y) + sgn * dy, `TANK_Y_MIN + `TANK_SIZE,
                                 `TANK_Y_MAX - `TANK_SIZE));
        end
        else if (c == cmdTurnLeft)
            a = angleT'((int'(a) + 1) % `ANGLE_COUNT);
        else if (c == cmdTurnRight)
            a = angleT'((int'(a) + `ANGLE_COUNT - 1) % `ANGLE_COUNT);
    endtask

    task automatic stepModel();
        int   distX, distY;
        logic over;
        distX = int'(mX1) - int'(mX2);
        distY = int'(mY1) - int'(mY2);
        if (distX < 0)
            distX = -distX;
        if (distY < 0)
            distY = -distY;
        over = (distX < 2 * `TANK_SIZE) && (distY < 2 * `TANK_SIZE);   // Positions before the edge
        if (over && !mHit && mCount < (1 << `HIT_COUNT_WIDTH) - 1)
            mCount = mCount + 1;
        mHit = over;
        moveTank(mX1, mY1, mA1, mAct1);
        moveTank(mX2, mY2, mA2, mAct2);
        if (keyAck && !prevAck)                 // New packet active from the next edge
        begin
            mAct1 = pickCommand(keycode, 8'h1A, 8'h16, 8'h04, 8'h07);
            mAct2 = pickCommand(keycode, 8'h52, 8'h51, 8'h50, 8'h4F);
        end
        prevAck = keyAck;
    endtask

    task automatic nextFrame();
        @(negedge Reset);                       // Outputs settled, safe to drive
        stepModel();
    endtask

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic checkCoord(input string name, input string what, input coordT exp,
                              input coordT act);
        if (act !== exp)
        begin
            $display("ERROR %s %s: expected %0d, actual %0d", name, what, exp, act);
            valueErrors++;
        end
    endtask

    task automatic checkAngle(input string name, input string what, input angleT exp,
                              input angleT act);
        if (act !== exp)
        begin
            $display("ERROR %s %s: expected %0d, actual %0d", name, what, exp, act);
            valueErrors++;
        end
    endtask

    task automatic checkHit(input string name, input string what, input logic exp,
                            input logic act);
        if (act !== exp)
        begin
            $display("ERROR %s %s: expected %b, actual %b", name, what, exp, act);
            valueErrors++;
        end
    endtask

    task automatic checkCount(input string name, input countT exp, input countT act);
        if (act !== exp)
        begin
            $display("ERROR %s hitCount: expected %0d, actual %0d", name, exp, act);
            valueErrors++;
        end
    endtask

    task automatic checkAll(input string name);
        checkCoord(name, "tank1X", mX1, tank1X);
        checkCoord(name, "tank1Y", mY1, tank1Y);
        checkAngle(name, "tank1Angle", mA1, tank1Angle);
        checkCoord(name, "tank2X", mX2, tank2X);
        checkCoord(name, "tank2Y", mY2, tank2Y);
        checkAngle(name, "tank2Angle", mA2, tank2Angle);
        checkHit(name, "hit", mHit, hit);
        checkHit(name, "keyAck", 1'b0, keyAck);
        checkCount(name, countT'(mCount), hitCount);
    endtask

    // Four-phase packet, each phase bounded by AckLimit frames
    task automatic sendPacket(input string name, input logic [31:0] code);
        int waited;
        keycode = code;
        keyReq  = 1'b1;
        waited  = 0;
        while (keyAck !== 1'b1 && waited < AckLimit)
        begin
            nextFrame();
            waited++;
        end
        if (keyAck !== 1'b1)
        begin
            $display("Packet for %s was never acknowledged", name);
            protoErrors++;
        end
        keyReq = 1'b0;
        waited = 0;
        while (keyAck !== 1'b0 && waited < AckLimit)
        begin
            nextFrame();
            waited++;
        end
        if (keyAck !== 1'b0)
        begin
            $display("Acknowledge for %s never dropped after the request ended", name);
            protoErrors++;
        end
    endtask

    task automatic addRow(input string name, input logic [31:0] code, input int hold,
                          input int hits);
        names.push_back(name);
        codes.push_back(code);
        holds.push_back(hold);
        expHits.push_back(hits);
    endtask

    always @(posedge Reset)
    begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit)
        begin
            $display("Run stopped after %0d frames without finishing the table", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial
    begin
        $readmemh("trig.mem", trigRom);
        addRow("ram tank 2", 32'h0000_001A, 33, 1);      // Tank 1 drives into tank 2
        addRow("back out 1", 32'h0000_0016, 10, -1);
        addRow("ram again", 32'h0000_001A, 10, -1);
        addRow("back out 2", 32'h0000_0016, 10, 2);
        addRow("p1 left wrap", 32'h0000_0004, 49, -1);   // Passes 44 back to 0
        addRow("p2 right turn", 32'h0000_004F, 20, -1);
        addRow("p1 forward", 32'h0000_001A, 8, -1);
        addRow("p2 backward", 32'h0000_0051, 8, -1);
        addRow("priority mix", 32'h1A16_5000, 6, -1);    // W wins over S, P2 turns left
        addRow("p1 corner clamp", 32'h0000_001A, 60, -1);
        addRow("p2 wall clamp", 32'h0000_0051, 80, -1);  // Ends in tank 1's corner
        addRow("release", 32'h0000_0000, 4, -1);
        foreach (holds[i])
            cycleLimit += holds[i] + 20;
        frame_clk = 1'b1;
        keyReq    = 1'b0;
        keycode   = '0;
        repeat (2) @(posedge Reset);
        @(negedge Reset);
        frame_clk = 1'b0;
        mX1     = coordT'(`TANK1_START_X);
        mY1     = coordT'(`TANK1_START_Y);
        mX2     = coordT'(`TANK2_START_X);
        mY2     = coordT'(`TANK2_START_Y);
        mA1     = '0;
        mA2     = '0;
        mAct1   = cmdNone;
        mAct2   = cmdNone;
        mHit    = 1'b0;
        mCount  = 0;
        prevAck = 1'b0;
        checkAll("reset");
        for (int r = 0; r < names.size(); r++)
        begin
            sendPacket(names[r], codes[r]);
            repeat (holds[r]) nextFrame();
            checkAll(names[r]);
            if (expHits[r] >= 0)
                checkCount({names[r], " total"}, countT'(expHits[r]), hitCount);
        end
        $display("Checks done with %0d value errors and %0d handshake errors",
                 valueErrors, protoErrors);
        if (valueErrors == 0 && protoErrors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: trig.mem
// Word per heading 0..44 in 8 degree steps, sine byte then cosine byte
// Both bytes sign-magnitude, bit 7 sign, bits 6:0 magnitude scaled by 127
007F
127E
237A
3474
436C
5261
5E55
6947
7238
7927
7D16
7F04
7E8D
7B9F
76B0
6EC0
64CE
58DB
4BE7
3CF0
2BF7
1AFC
09FF
89FF
9AFC
ABF7
BCF0
CBE7
D8DB
E4CE
EEC0
F6B0
FB9F
FE8D
FF04
FD16
F927
F238
E947
DE55
D261
C36C
B474
A37A
927E

// File: sources.f
+incdir+.
tank_pkg.sv
keyboardDecoder.sv
trigTable.sv
tankMotion.sv
hitDetector.sv
tankArena.sv
tankArena_assertions.sv
tb_tankArena.sv

// File: run.sh
#!/bin/sh
# Compile and run the tank arena testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_tankArena \
    -f sources.f -o sim_tankArena

./obj_dir/sim_tankArena | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
